/* Makefile */
TOP = tb_mpsoc
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf $(OBJ) sim.log

/* build.f */
+incdir+logic
logic/isa_pkg.sv
logic/trace_pkg.sv
logic/mini_core.sv
logic/r3_tracker.sv
logic/term_monitor.sv
logic/mpsoc_top.sv
tests/tb_clock.sv
tests/tb_mpsoc.sv

/* logic/isa_pkg.sv */
`include "mpsoc_cfg.svh"

package isa_pkg;

  // Opcode sits in the top nibble of every instruction word
  // Codes not listed here retire as no-ops
  typedef enum logic [3:0] {
    ADD  = 4'h1,
    SUB  = 4'h2,
    XOR  = 4'h3,
    ADDI = 4'h4,
    BNEZ = 4'h5,
    EXIT = 4'hf
  } opcode_t;

  typedef logic [$clog2(`MPSOC_NUM_REGS)-1:0] reg_idx_t;

  localparam int unsigned IMM_W = 16;

  // Register view: rd = ra op rb
  typedef struct packed {
    opcode_t     op;
    reg_idx_t    rd;
    reg_idx_t    ra;
    reg_idx_t    rb;
    logic [15:0] unused;
  } insn_reg_t;

  // Immediate view, immediate in the low half
  typedef struct packed {
    opcode_t          op;
    reg_idx_t         rd;
    reg_idx_t         ra;
    logic [3:0]       rsvd;
    logic [IMM_W-1:0] imm;
  } insn_imm_t;

  typedef union packed {
    insn_reg_t r;
    insn_imm_t i;
  } insn_u;

endpackage

/* logic/mini_core.sv */
`timescale 1ns/1ps
`include "mpsoc_cfg.svh"

module mini_core (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                run_i,
  input  logic                imem_we_i,
  input  trace_pkg::pc_t      imem_addr_i,
  input  trace_pkg::word_t    imem_data_i,
  output logic                trace_valid_o,
  output trace_pkg::pc_t      trace_pc_o,
  output trace_pkg::word_t    trace_insn_o,
  output logic                trace_wben_o,
  output isa_pkg::reg_idx_t   trace_wbreg_o,
  output trace_pkg::word_t    trace_wbdata_o
);

  import isa_pkg::*;
  import trace_pkg::*;

  word_t    imem [`MPSOC_IMEM_DEPTH];
  word_t    rf   [`MPSOC_NUM_REGS];

  pc_t      pc_q;
  logic     halted_q;
  logic     core_en;

  insn_u    insn;
  word_t    ra_val;
  word_t    rb_val;
  word_t    imm_ext;

  logic     wb_en;
  reg_idx_t wb_reg;
  word_t    wb_data;
  pc_t      next_pc;
  logic     is_exit;

  // One retirement per cycle while running and not yet halted
  assign core_en = run_i && !halted_q;

  // Program loading port used while run_i is low
  always_ff @(posedge clk_i) begin
    if (imem_we_i) begin
      imem[imem_addr_i] <= imem_data_i;
    end
  end

  // Fetch is combinational from the current pc
  assign insn = imem[pc_q];

  // r0 is hardwired to zero on the read side
  assign ra_val = (insn.r.ra == '0) ? '0 : rf[insn.r.ra];
  assign rb_val = (insn.r.rb == '0) ? '0 : rf[insn.r.rb];

  assign imm_ext = {{(`MPSOC_XLEN - IMM_W){insn.i.imm[IMM_W-1]}}, insn.i.imm};

  // Decode and execute with the view chosen by opcode
  always_comb begin
    wb_en   = 1'b0;
    wb_reg  = insn.r.rd;
    wb_data = '0;
    next_pc = pc_q + pc_t'(1);
    is_exit = 1'b0;
    case (insn.r.op)
      ADD: begin
        wb_en   = 1'b1;
        wb_data = ra_val + rb_val;
      end
      SUB: begin
        wb_en   = 1'b1;
        wb_data = ra_val - rb_val;
      end
      XOR: begin
        wb_en   = 1'b1;
        wb_data = ra_val ^ rb_val;
      end
      ADDI: begin
        wb_en   = 1'b1;
        wb_data = ra_val + imm_ext;
      end
      BNEZ: begin
        // Offset wraps within the memory and so acts as signed
        if (ra_val != '0) begin
          next_pc = pc_q + pc_t'(insn.i.imm);
        end
      end
      EXIT: begin
        is_exit = 1'b1;
        next_pc = pc_q;
      end
      default: begin
      end
    endcase
  end

  // Control state and register file
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q          <= '0;
      halted_q      <= 1'b0;
      trace_valid_o <= 1'b0;
      for (int r = 0; r < `MPSOC_NUM_REGS; r++) begin
        rf[r] <= '0;
      end
    end else begin
      trace_valid_o <= core_en;
      if (core_en) begin
        pc_q     <= next_pc;
        halted_q <= is_exit;
        // Writes to r0 are dropped but still show on the trace
        if (wb_en && wb_reg != '0) begin
          rf[wb_reg] <= wb_data;
        end
      end
    end
  end

  // Trace payload is qualified by trace_valid_o
  always_ff @(posedge clk_i) begin
    if (core_en) begin
      trace_pc_o     <= pc_q;
      trace_insn_o   <= insn;
      trace_wben_o   <= wb_en;
      trace_wbreg_o  <= wb_reg;
      trace_wbdata_o <= wb_data;
    end
  end

endmodule

/* logic/mpsoc_cfg.svh */
`ifndef MPSOC_CFG_SVH
`define MPSOC_CFG_SVH

// Number of cores in the system
`define MPSOC_NUM_CORES 2

// Instruction words held by each core
`define MPSOC_IMEM_DEPTH 32

// Data word width
`define MPSOC_XLEN 32

// Architectural registers per core, r0 included
`define MPSOC_NUM_REGS 16

`endif

/* logic/mpsoc_top.sv */
`timescale 1ns/1ps
`include "mpsoc_cfg.svh"

module mpsoc_top (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                                       run_i,
  input  logic                                       imem_we_i,
  input  logic [$clog2(`MPSOC_NUM_CORES)-1:0]        imem_core_i,
  input  trace_pkg::pc_t                             imem_addr_i,
  input  trace_pkg::word_t                           imem_data_i,
  output logic [`MPSOC_NUM_CORES-1:0]                trace_valid_o,
  output trace_pkg::pc_t [`MPSOC_NUM_CORES-1:0]      trace_pc_o,
  output trace_pkg::word_t [`MPSOC_NUM_CORES-1:0]    trace_insn_o,
  output logic [`MPSOC_NUM_CORES-1:0]                trace_wben_o,
  output isa_pkg::reg_idx_t [`MPSOC_NUM_CORES-1:0]   trace_wbreg_o,
  output trace_pkg::word_t [`MPSOC_NUM_CORES-1:0]    trace_wbdata_o,
  output logic [`MPSOC_NUM_CORES-1:0]                done_o,
  output trace_pkg::word_t [`MPSOC_NUM_CORES-1:0]    exit_code_o,
  output logic                                       all_done_o
);

  import isa_pkg::*;
  import trace_pkg::*;

  localparam int unsigned CORE_W = $clog2(`MPSOC_NUM_CORES);

  logic [`MPSOC_NUM_CORES-1:0]  core_we;
  logic [`MPSOC_NUM_CORES-1:0]  exit_seen;
  word_t [`MPSOC_NUM_CORES-1:0] r3;

  for (genvar c = 0; c < `MPSOC_NUM_CORES; c++) begin : gen_core
    insn_u trace_insn;

    // Load strobe goes only to the selected core
    assign core_we[c] = imem_we_i && (imem_core_i == CORE_W'(c));

    // Exit detection on the retired instruction word
    assign trace_insn   = trace_insn_o[c];
    assign exit_seen[c] = (trace_insn.r.op == EXIT);

    mini_core u_core (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .run_i          (run_i),
      .imem_we_i      (core_we[c]),
      .imem_addr_i    (imem_addr_i),
      .imem_data_i    (imem_data_i),
      .trace_valid_o  (trace_valid_o[c]),
      .trace_pc_o     (trace_pc_o[c]),
      .trace_insn_o   (trace_insn_o[c]),
      .trace_wben_o   (trace_wben_o[c]),
      .trace_wbreg_o  (trace_wbreg_o[c]),
      .trace_wbdata_o (trace_wbdata_o[c])
    );

    r3_tracker u_r3_tracker (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .trace_valid_i  (trace_valid_o[c]),
      .trace_wben_i   (trace_wben_o[c]),
      .trace_wbreg_i  (trace_wbreg_o[c]),
      .trace_wbdata_i (trace_wbdata_o[c]),
      .r3_o           (r3[c])
    );
  end

  term_monitor u_term_monitor (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .trace_valid_i (trace_valid_o),
    .exit_seen_i   (exit_seen),
    .r3_i          (r3),
    .done_o        (done_o),
    .exit_code_o   (exit_code_o),
    .all_done_o    (all_done_o)
  );

endmodule

/* logic/r3_tracker.sv */
`timescale 1ns/1ps

module r3_tracker (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                trace_valid_i,
  input  logic                trace_wben_i,
  input  isa_pkg::reg_idx_t   trace_wbreg_i,
  input  trace_pkg::word_t    trace_wbdata_i,
  output trace_pkg::word_t    r3_o
);

  import trace_pkg::*;

  logic r3_write;

  // Only write-backs that land in the exit register matter
  assign r3_write = trace_valid_i && trace_wben_i && (trace_wbreg_i == EXIT_REG);

  // Shadow copy, one cycle behind the trace
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r3_o <= '0;
    end else if (r3_write) begin
      r3_o <= trace_wbdata_i;
    end
  end

endmodule

/* logic/term_monitor.sv */
`timescale 1ns/1ps
`include "mpsoc_cfg.svh"

module term_monitor (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic [`MPSOC_NUM_CORES-1:0]              trace_valid_i,
  input  logic [`MPSOC_NUM_CORES-1:0]              exit_seen_i,
  input  trace_pkg::word_t [`MPSOC_NUM_CORES-1:0]  r3_i,
  output logic [`MPSOC_NUM_CORES-1:0]              done_o,
  output trace_pkg::word_t [`MPSOC_NUM_CORES-1:0]  exit_code_o,
  output logic                                     all_done_o
);

  logic [`MPSOC_NUM_CORES-1:0] exit_hit;

  // First EXIT beat from each core ends that core
  assign exit_hit = trace_valid_i & exit_seen_i & ~done_o;

  // Sticky per-core done flags
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o <= '0;
    end else begin
      done_o <= done_o | exit_hit;
    end
  end

  // Exit code is captured together with the done flag
  always_ff @(posedge clk_i) begin
    for (int c = 0; c < `MPSOC_NUM_CORES; c++) begin
      if (exit_hit[c]) begin
        exit_code_o[c] <= r3_i[c];
      end
    end
  end

  // Rises with the last done flag
  assign all_done_o = &done_o;

endmodule

/* logic/trace_pkg.sv */
`include "mpsoc_cfg.svh"

package trace_pkg;

  // Instruction address into one core's memory
  typedef logic [$clog2(`MPSOC_IMEM_DEPTH)-1:0] pc_t;

  // Data word as carried on the trace
  typedef logic [`MPSOC_XLEN-1:0] word_t;

  // Programs leave their exit code in r3
  localparam isa_pkg::reg_idx_t EXIT_REG = 4'd3;

endpackage

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int unsigned PERIOD_NS = 40
) (
  output logic clk_o
);

  // Free-running clock, low for the first half period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule

/* tests/tb_mpsoc.sv */
`timescale 1ns/1ps
`include "mpsoc_cfg.svh"

module tb_mpsoc;

  import isa_pkg::*;
  import trace_pkg::*;

  localparam int NC           = `MPSOC_NUM_CORES;
  localparam int DEPTH        = `MPSOC_IMEM_DEPTH;
  localparam int CORE_W       = $clog2(`MPSOC_NUM_CORES);
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_BEATS    = 64;

  logic                  clk;
  logic                  rst_n;
  logic                  run;
  logic                  imem_we;
  logic [CORE_W-1:0]     imem_core;
  pc_t                   imem_addr;
  word_t                 imem_data;
  logic [NC-1:0]         trace_valid;
  pc_t [NC-1:0]          trace_pc;
  word_t [NC-1:0]        trace_insn;
  logic [NC-1:0]         trace_wben;
  reg_idx_t [NC-1:0]     trace_wbreg;
  word_t [NC-1:0]        trace_wbdata;
  logic [NC-1:0]         done;
  word_t [NC-1:0]        exit_code;
  logic                  all_done;

  integer   seed;
  int       limit_cycles;
  word_t    prog       [NC][DEPTH];
  pc_t      exp_pc     [NC][MAX_BEATS];
  word_t    exp_insn   [NC][MAX_BEATS];
  logic     exp_wben   [NC][MAX_BEATS];
  reg_idx_t exp_wbreg  [NC][MAX_BEATS];
  word_t    exp_wbdata [NC][MAX_BEATS];
  word_t    exp_r3     [NC];
  int       exp_count  [NC];
  int       beat_idx   [NC];

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk_o(clk));

  mpsoc_top dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .run_i          (run),
    .imem_we_i      (imem_we),
    .imem_core_i    (imem_core),
    .imem_addr_i    (imem_addr),
    .imem_data_i    (imem_data),
    .trace_valid_o  (trace_valid),
    .trace_pc_o     (trace_pc),
    .trace_insn_o   (trace_insn),
    .trace_wben_o   (trace_wben),
    .trace_wbreg_o  (trace_wbreg),
    .trace_wbdata_o (trace_wbdata),
    .done_o         (done),
    .exit_code_o    (exit_code),
    .all_done_o     (all_done)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL time=%0t signal=%s expected=0x%08h actual=0x%08h",
               $time, name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  function automatic word_t encode_reg(input logic [3:0] op, input logic [3:0] rd,
                                       input logic [3:0] ra, input logic [3:0] rb);
    return {op, rd, ra, rb, 16'h0000};
  endfunction

  function automatic word_t encode_imm(input logic [3:0] op, input logic [3:0] rd,
                                       input logic [3:0] ra, input logic [15:0] imm);
    return {op, rd, ra, 4'h0, imm};
  endfunction

  // Instruction-level model with one entry per retirement
  function automatic int run_model(input int core);
    word_t       regs [`MPSOC_NUM_REGS];
    word_t       w;
    word_t       a;
    word_t       b;
    word_t       imm_s;
    word_t       res;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic        wr;
    pc_t         pc;
    int          n;
    for (int r = 0; r < `MPSOC_NUM_REGS; r++) begin
      regs[r] = '0;
    end
    pc = '0;
    n  = 0;
    while (n < MAX_BEATS) begin
      w     = prog[core][pc];
      op    = w[31:28];
      rd    = w[27:24];
      a     = regs[w[23:20]];
      b     = regs[w[19:16]];
      imm_s = {{16{w[15]}}, w[15:0]};
      wr    = 1'b1;
      res   = '0;
      case (op)
        ADD:     res = a + b;
        SUB:     res = a - b;
        XOR:     res = a ^ b;
        ADDI:    res = a + imm_s;
        default: wr = 1'b0;
      endcase
      exp_pc[core][n]     = pc;
      exp_insn[core][n]   = w;
      exp_wben[core][n]   = wr;
      exp_wbreg[core][n]  = rd;
      exp_wbdata[core][n] = res;
      n++;
      // r0 keeps reading as zero
      if (wr && rd != 4'd0) begin
        regs[rd] = res;
      end
      if (op == EXIT) begin
        break;
      end
      if (op == BNEZ && a != '0) begin
        pc = pc + pc_t'(imm_s);
      end else begin
        pc = pc + pc_t'(1);
      end
    end
    exp_r3[core] = regs[3];
    return n;
  endfunction

  task automatic build_programs();
    logic [15:0] imm1;
    logic [15:0] imm2;
    logic [15:0] imm3;
    logic [15:0] step;
    logic [15:0] loops;
    for (int c = 0; c < NC; c++) begin
      for (int a = 0; a < DEPTH; a++) begin
        // Unused words decode as no-ops tagged with core and address
        prog[c][a] = 32'h0a50_0000 | 32'(c << 8) | 32'(a);
      end
    end
    imm1  = 16'($random(seed));
    imm2  = 16'($random(seed));
    imm3  = 16'($random(seed));
    step  = 16'($random(seed));
    loops = 16'(3 + (($random(seed) & 32'h7fff_ffff) % 5));
    // Core 0 runs straight-line ALU code with a write to r0
    prog[0][0] = encode_imm(ADDI, 4'd1, 4'd0, imm1);
    prog[0][1] = encode_imm(ADDI, 4'd2, 4'd0, imm2);
    prog[0][2] = encode_reg(ADD, 4'd3, 4'd1, 4'd2);
    prog[0][3] = encode_reg(SUB, 4'd4, 4'd3, 4'd1);
    prog[0][4] = encode_reg(XOR, 4'd5, 4'd4, 4'd1);
    prog[0][5] = encode_imm(ADDI, 4'd0, 4'd1, imm3);
    prog[0][6] = encode_reg(ADD, 4'd6, 4'd0, 4'd5);
    prog[0][7] = encode_reg(XOR, 4'd3, 4'd3, 4'd6);
    prog[0][8] = encode_imm(EXIT, 4'd0, 4'd0, 16'h0000);
    // Core 1 runs a countdown loop that accumulates into r3
    prog[1][0] = encode_imm(ADDI, 4'd1, 4'd0, loops);
    prog[1][1] = encode_imm(ADDI, 4'd2, 4'd0, step);
    prog[1][2] = encode_reg(ADD, 4'd3, 4'd3, 4'd2);
    prog[1][3] = encode_imm(ADDI, 4'd1, 4'd1, 16'hffff);
    prog[1][4] = encode_imm(BNEZ, 4'd0, 4'd1, 16'hfffe);
    prog[1][5] = encode_imm(EXIT, 4'd0, 4'd0, 16'h0000);
  endtask

  task automatic load_programs();
    for (int c = 0; c < NC; c++) begin
      for (int a = 0; a < DEPTH; a++) begin
        imem_we   = 1'b1;
        imem_core = CORE_W'(c);
        imem_addr = pc_t'(a);
        imem_data = prog[c][a];
        @(negedge clk);
      end
    end
    imem_we = 1'b0;
  endtask

  // Every trace beat is matched against the next model step
  always @(posedge clk) begin : compare_beats
    logic all_finished;
    int   k;
    if (rst_n) begin
      all_finished = 1'b1;
      for (int c = 0; c < NC; c++) begin
        check_value($sformatf("done_o[%0d]", c), 32'(beat_idx[c] == exp_count[c]),
                    32'(done[c]));
        all_finished = all_finished && (beat_idx[c] == exp_count[c]);
      end
      check_value("all_done_o", 32'(all_finished), 32'(all_done));
      for (int c = 0; c < NC; c++) begin
        if (trace_valid[c]) begin
          k = beat_idx[c];
          if (k >= exp_count[c]) begin
            abort_run($sformatf("Core %0d retired an instruction after its EXIT", c));
          end else begin
            check_value($sformatf("trace_pc_o[%0d]", c), 32'(exp_pc[c][k]),
                        32'(trace_pc[c]));
            check_value($sformatf("trace_insn_o[%0d]", c), exp_insn[c][k], trace_insn[c]);
            check_value($sformatf("trace_wben_o[%0d]", c), 32'(exp_wben[c][k]),
                        32'(trace_wben[c]));
            if (exp_wben[c][k]) begin
              check_value($sformatf("trace_wbreg_o[%0d]", c), 32'(exp_wbreg[c][k]),
                          32'(trace_wbreg[c]));
              check_value($sformatf("trace_wbdata_o[%0d]", c), exp_wbdata[c][k],
                          trace_wbdata[c]);
            end
            beat_idx[c] = k + 1;
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout, all_done never rose within %0d cycles", limit_cycles);
    $display("STATUS: FAIL");
    $fatal(1);
  end

  initial begin : main
    int max_count;
    seed      = 32'h8585_219f;
    rst_n     = 1'b0;
    run       = 1'b0;
    imem_we   = 1'b0;
    imem_core = '0;
    imem_addr = '0;
    imem_data = '0;
    max_count = 0;
    for (int c = 0; c < NC; c++) begin
      beat_idx[c] = 0;
    end
    build_programs();
    for (int c = 0; c < NC; c++) begin
      exp_count[c] = run_model(c);
      if (exp_count[c] > max_count) begin
        max_count = exp_count[c];
      end
    end
    limit_cycles = max_count + RESET_CYCLES + NC * DEPTH + 40;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    load_programs();

    // Nothing may retire or finish before run rises
    check_value("trace_valid_o", '0, 32'(trace_valid));
    check_value("done_o", '0, 32'(done));
    check_value("all_done_o", '0, 32'(all_done));

    run = 1'b1;
    @(negedge clk);
    while (!all_done) begin
      @(negedge clk);
    end
    for (int c = 0; c < NC; c++) begin
      check_value($sformatf("exit_code_o[%0d]", c), exp_r3[c], exit_code[c]);
    end

    // Status must hold with the cores halted
    repeat (4) @(negedge clk);
    for (int c = 0; c < NC; c++) begin
      check_value($sformatf("exit_code_o[%0d]", c), exp_r3[c], exit_code[c]);
    end
    check_value("trace_valid_o", '0, 32'(trace_valid));
    check_value("all_done_o", 32'd1, 32'(all_done));
    $display("STATUS: PASS");
    $finish;
  end

endmodule
